// ==== files.f ====
+incdir+hw
hw/axil_pkg.sv
hw/axil_reg_target.sv
hw/axil_mem_target.sv
hw/axil_split.sv
hw/axil_split_top.sv
testbench/tb_axil_split.sv

// ==== hw/axil_mem_target.sv ====
// AXI4-Lite word memory target with a two-stage read pipeline
`timescale 1ns/1ps
`include "axil_settings.svh"

module axil_mem_target (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AXIL_DATA_WIDTH-1:0] wdata,
  input  logic [`AXIL_STRB_WIDTH-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output axil_pkg::axil_resp_e        bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`AXIL_DATA_WIDTH-1:0] rdata,
  output axil_pkg::axil_resp_e        rresp,
  output logic                        rvalid,
  input  logic                        rready
);

  import axil_pkg::*;

  localparam int idx_width = $clog2(`AXIL_MEM_WORDS);

  logic [`AXIL_DATA_WIDTH-1:0] mem [`AXIL_MEM_WORDS];
  logic [`AXIL_DATA_WIDTH-1:0] s1_data;
  logic [`AXIL_DATA_WIDTH-1:0] s2_data;
  mem_stage_e                  s1_state;
  mem_stage_e                  s2_state;
  logic                        wr_accept;
  logic                        ar_accept;
  logic                        s2_load;
  logic                        r_done;

  // Every access succeeds
  assign bresp = OKAY;
  assign rresp = OKAY;

  // ----------------------------------------------------------
  // Write path
  // ----------------------------------------------------------
  // No new write while a response is still pending
  assign wr_accept = !bvalid && awvalid && wvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid <= 1'b0;
    end else if (wr_accept) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
        if (wstrb[b]) begin
          mem[awaddr[idx_width+1:2]][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read pipeline
  // ----------------------------------------------------------
  // Stage 1 holds the array output, stage 2 drives the R channel
  assign r_done    = (s2_state == FULL) && rready;
  assign s2_load   = (s1_state == FULL) && ((s2_state == EMPTY) || rready);
  assign arready   = (s1_state == EMPTY) || (s2_state == EMPTY) || rready;
  assign ar_accept = arvalid && arready;
  assign rvalid    = (s2_state == FULL);
  assign rdata     = s2_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_state <= EMPTY;
      s2_state <= EMPTY;
    end else begin
      if (ar_accept) begin
        s1_state <= FULL;
      end else if (s2_load) begin
        s1_state <= EMPTY;
      end
      if (s2_load) begin
        s2_state <= FULL;
      end else if (r_done) begin
        s2_state <= EMPTY;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_accept) begin
      s1_data <= mem[araddr[idx_width+1:2]];
    end
    if (s2_load) begin
      s2_data <= s1_data;
    end
  end

endmodule

// ==== hw/axil_pkg.sv ====
// Shared enums for the AXI4-Lite split and its two targets
package axil_pkg;

  // AXI response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Register target sequencing
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    WRITE_RESP = 2'd1,
    READ_RESP  = 2'd2
  } reg_state_e;

  // Memory read pipeline stage occupancy
  typedef enum logic {
    EMPTY = 1'b0,
    FULL  = 1'b1
  } mem_stage_e;

endpackage

// ==== hw/axil_reg_target.sv ====
// AXI4-Lite control register bank with ID register and write counter
`timescale 1ns/1ps
`include "axil_settings.svh"

module axil_reg_target (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AXIL_DATA_WIDTH-1:0] wdata,
  input  logic [`AXIL_STRB_WIDTH-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output axil_pkg::axil_resp_e        bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`AXIL_DATA_WIDTH-1:0] rdata,
  output axil_pkg::axil_resp_e        rresp,
  output logic                        rvalid,
  input  logic                        rready
);

  import axil_pkg::*;

  localparam int idx_width = $clog2(`AXIL_REG_COUNT);
  // Last two entries are the ID and the write counter
  localparam int rw_count  = `AXIL_REG_COUNT - 2;
  localparam int id_index  = `AXIL_REG_COUNT - 2;

  reg_state_e                  state;
  logic [`AXIL_DATA_WIDTH-1:0] regs [rw_count];
  logic [`AXIL_DATA_WIDTH-1:0] wr_counter;
  logic [`AXIL_DATA_WIDTH-1:0] rd_word;
  logic [idx_width-1:0]        wr_idx;
  logic [idx_width-1:0]        rd_idx;
  logic                        wr_writable;
  logic                        wr_accept;
  logic                        rd_accept;

  assign wr_idx      = awaddr[idx_width+1:2];
  assign rd_idx      = araddr[idx_width+1:2];
  assign wr_writable = int'(wr_idx) < rw_count;

  // One transaction at a time; a write wins over a read in the same cycle
  assign wr_accept = (state == IDLE) && awvalid && wvalid;
  assign rd_accept = (state == IDLE) && arvalid && !(awvalid && wvalid);

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;
  assign bvalid  = (state == WRITE_RESP);
  assign rvalid  = (state == READ_RESP);
  assign rresp   = OKAY;

  // ----------------------------------------------------------
  // Sequencing and register writes
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      wr_counter <= '0;
      for (int i = 0; i < rw_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        IDLE: begin
          if (wr_accept) begin
            state <= WRITE_RESP;
          end else if (rd_accept) begin
            state <= READ_RESP;
          end
        end
        WRITE_RESP: if (bready) state <= IDLE;
        READ_RESP:  if (rready) state <= IDLE;
        default:    state <= IDLE;
      endcase

      if (wr_accept && wr_writable) begin
        for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
          if (wstrb[b]) begin
            regs[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
        // Wraps naturally at the full data width
        wr_counter <= wr_counter + 1'b1;
      end
    end
  end

  // Read data selection
  always_comb begin
    if (int'(rd_idx) < rw_count) begin
      rd_word = regs[rd_idx];
    end else if (int'(rd_idx) == id_index) begin
      rd_word = `AXIL_REG_ID_VALUE;
    end else begin
      rd_word = wr_counter;
    end
  end

  // Response payload, held until the response is taken
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp <= wr_writable ? OKAY : SLVERR;
    end
    if (rd_accept) begin
      rdata <= rd_word;
    end
  end

endmodule

// ==== hw/axil_settings.svh ====
// AXI4-Lite split widths, depths and constants shared by RTL and testbench
`ifndef AXIL_SETTINGS_SVH
`define AXIL_SETTINGS_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------
`define AXIL_ADDR_WIDTH 16
`define AXIL_DATA_WIDTH 32
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

// Outstanding transactions per direction in the split
`define AXIL_MAX_OUTSTANDING 2

// ----------------------------------------------------------
// Targets
// ----------------------------------------------------------
// Trunk memory depth in words, indexed by address bits 9:2
`define AXIL_MEM_WORDS 256

// Branch register count, indexed by address bits 4:2
`define AXIL_REG_COUNT 8

// Read-only value of register 6
`define AXIL_REG_ID_VALUE 32'h5A11_0C01

`endif

// ==== hw/axil_split.sv ====
// AXI4-Lite 1:2 address split with ordering guard and response merge
`timescale 1ns/1ps
`include "axil_settings.svh"

module axil_split (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`AXIL_ADDR_WIDTH-1:0] branch_start_addr,
  input  logic [`AXIL_ADDR_WIDTH-1:0] branch_end_addr,

  // Root side, driven by the initiator
  input  logic [`AXIL_ADDR_WIDTH-1:0] root_awaddr,
  input  logic                        root_awvalid,
  output logic                        root_awready,
  input  logic [`AXIL_DATA_WIDTH-1:0] root_wdata,
  input  logic [`AXIL_STRB_WIDTH-1:0] root_wstrb,
  input  logic                        root_wvalid,
  output logic                        root_wready,
  output axil_pkg::axil_resp_e        root_bresp,
  output logic                        root_bvalid,
  input  logic                        root_bready,
  input  logic [`AXIL_ADDR_WIDTH-1:0] root_araddr,
  input  logic                        root_arvalid,
  output logic                        root_arready,
  output logic [`AXIL_DATA_WIDTH-1:0] root_rdata,
  output axil_pkg::axil_resp_e        root_rresp,
  output logic                        root_rvalid,
  input  logic                        root_rready,

  // Branch side
  output logic [`AXIL_ADDR_WIDTH-1:0] branch_awaddr,
  output logic                        branch_awvalid,
  input  logic                        branch_awready,
  output logic [`AXIL_DATA_WIDTH-1:0] branch_wdata,
  output logic [`AXIL_STRB_WIDTH-1:0] branch_wstrb,
  output logic                        branch_wvalid,
  input  logic                        branch_wready,
  input  axil_pkg::axil_resp_e        branch_bresp,
  input  logic                        branch_bvalid,
  output logic                        branch_bready,
  output logic [`AXIL_ADDR_WIDTH-1:0] branch_araddr,
  output logic                        branch_arvalid,
  input  logic                        branch_arready,
  input  logic [`AXIL_DATA_WIDTH-1:0] branch_rdata,
  input  axil_pkg::axil_resp_e        branch_rresp,
  input  logic                        branch_rvalid,
  output logic                        branch_rready,

  // Trunk side
  output logic [`AXIL_ADDR_WIDTH-1:0] trunk_awaddr,
  output logic                        trunk_awvalid,
  input  logic                        trunk_awready,
  output logic [`AXIL_DATA_WIDTH-1:0] trunk_wdata,
  output logic [`AXIL_STRB_WIDTH-1:0] trunk_wstrb,
  output logic                        trunk_wvalid,
  input  logic                        trunk_wready,
  input  axil_pkg::axil_resp_e        trunk_bresp,
  input  logic                        trunk_bvalid,
  output logic                        trunk_bready,
  output logic [`AXIL_ADDR_WIDTH-1:0] trunk_araddr,
  output logic                        trunk_arvalid,
  input  logic                        trunk_arready,
  input  logic [`AXIL_DATA_WIDTH-1:0] trunk_rdata,
  input  axil_pkg::axil_resp_e        trunk_rresp,
  input  logic                        trunk_rvalid,
  output logic                        trunk_rready
);

  import axil_pkg::*;

  localparam int count_width = $clog2(`AXIL_MAX_OUTSTANDING + 1);

  logic                   aw_in_branch;
  logic                   ar_in_branch;
  logic [count_width-1:0] wr_count;
  logic [count_width-1:0] rd_count;
  logic                   last_aw_branch;
  logic                   last_ar_branch;
  logic                   wr_allowed;
  logic                   rd_allowed;
  logic                   wr_request;
  logic                   aw_accept;
  logic                   ar_accept;
  logic                   b_done;
  logic                   r_done;

  // ----------------------------------------------------------
  // Decode and ordering guard
  // ----------------------------------------------------------
  assign aw_in_branch = (root_awaddr >= branch_start_addr) && (root_awaddr <= branch_end_addr);
  assign ar_in_branch = (root_araddr >= branch_start_addr) && (root_araddr <= branch_end_addr);

  // Same target as the last one, or nothing in flight, and room left
  assign wr_allowed = (wr_count != count_width'(`AXIL_MAX_OUTSTANDING)) &&
                      ((wr_count == '0) || (last_aw_branch == aw_in_branch));
  assign rd_allowed = (rd_count != count_width'(`AXIL_MAX_OUTSTANDING)) &&
                      ((rd_count == '0) || (last_ar_branch == ar_in_branch));

  // Address and data go out together
  assign wr_request = root_awvalid && root_wvalid && wr_allowed;

  assign branch_awvalid = wr_request && aw_in_branch;
  assign branch_wvalid  = wr_request && aw_in_branch;
  assign trunk_awvalid  = wr_request && !aw_in_branch;
  assign trunk_wvalid   = wr_request && !aw_in_branch;
  assign branch_arvalid = root_arvalid && rd_allowed && ar_in_branch;
  assign trunk_arvalid  = root_arvalid && rd_allowed && !ar_in_branch;

  assign root_awready = (branch_awvalid && branch_awready) || (trunk_awvalid && trunk_awready);
  assign root_wready  = (branch_wvalid && branch_wready) || (trunk_wvalid && trunk_wready);
  assign root_arready = (branch_arvalid && branch_arready) || (trunk_arvalid && trunk_arready);

  assign aw_accept = root_awvalid && root_awready;
  assign ar_accept = root_arvalid && root_arready;
  assign b_done    = root_bvalid && root_bready;
  assign r_done    = root_rvalid && root_rready;

  // In-flight counters and last-target flags
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_count       <= '0;
      rd_count       <= '0;
      last_aw_branch <= 1'b0;
      last_ar_branch <= 1'b0;
    end else begin
      if (aw_accept != b_done) begin
        wr_count <= aw_accept ? wr_count + 1'b1 : wr_count - 1'b1;
      end
      if (ar_accept != r_done) begin
        rd_count <= ar_accept ? rd_count + 1'b1 : rd_count - 1'b1;
      end
      if (aw_accept) begin
        last_aw_branch <= aw_in_branch;
      end
      if (ar_accept) begin
        last_ar_branch <= ar_in_branch;
      end
    end
  end

  // Requests are broadcast; only the valid tells the target apart
  assign branch_awaddr = root_awaddr;
  assign trunk_awaddr  = root_awaddr;
  assign branch_wdata  = root_wdata;
  assign trunk_wdata   = root_wdata;
  assign branch_wstrb  = root_wstrb;
  assign trunk_wstrb   = root_wstrb;
  assign branch_araddr = root_araddr;
  assign trunk_araddr  = root_araddr;

  // ----------------------------------------------------------
  // Response merge
  // ----------------------------------------------------------
  // At most one target responds at a time thanks to the guard above
  assign root_bvalid = branch_bvalid || trunk_bvalid;
  assign root_bresp  = axil_resp_e'(({2{branch_bvalid}} & branch_bresp) |
                                    ({2{trunk_bvalid}} & trunk_bresp));
  assign root_rvalid = branch_rvalid || trunk_rvalid;
  assign root_rresp  = axil_resp_e'(({2{branch_rvalid}} & branch_rresp) |
                                    ({2{trunk_rvalid}} & trunk_rresp));
  assign root_rdata  = ({`AXIL_DATA_WIDTH{branch_rvalid}} & branch_rdata) |
                       ({`AXIL_DATA_WIDTH{trunk_rvalid}} & trunk_rdata);

  assign branch_bready = root_bready;
  assign trunk_bready  = root_bready;
  assign branch_rready = root_rready;
  assign trunk_rready  = root_rready;

endmodule

// ==== hw/axil_split_top.sv ====
// Top level joining the AXI4-Lite split to its register and memory targets
`timescale 1ns/1ps
`include "axil_settings.svh"

module axil_split_top (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`AXIL_ADDR_WIDTH-1:0] branch_start_addr,
  input  logic [`AXIL_ADDR_WIDTH-1:0] branch_end_addr,
  input  logic [`AXIL_ADDR_WIDTH-1:0] root_awaddr,
  input  logic                        root_awvalid,
  output logic                        root_awready,
  input  logic [`AXIL_DATA_WIDTH-1:0] root_wdata,
  input  logic [`AXIL_STRB_WIDTH-1:0] root_wstrb,
  input  logic                        root_wvalid,
  output logic                        root_wready,
  output axil_pkg::axil_resp_e        root_bresp,
  output logic                        root_bvalid,
  input  logic                        root_bready,
  input  logic [`AXIL_ADDR_WIDTH-1:0] root_araddr,
  input  logic                        root_arvalid,
  output logic                        root_arready,
  output logic [`AXIL_DATA_WIDTH-1:0] root_rdata,
  output axil_pkg::axil_resp_e        root_rresp,
  output logic                        root_rvalid,
  input  logic                        root_rready
);

  import axil_pkg::*;

  // ----------------------------------------------------------
  // Split to target wiring
  // ----------------------------------------------------------
  logic [`AXIL_ADDR_WIDTH-1:0] branch_awaddr, branch_araddr;
  logic [`AXIL_DATA_WIDTH-1:0] branch_wdata, branch_rdata;
  logic [`AXIL_STRB_WIDTH-1:0] branch_wstrb;
  logic                        branch_awvalid, branch_awready, branch_wvalid, branch_wready;
  logic                        branch_bvalid, branch_bready, branch_arvalid, branch_arready;
  logic                        branch_rvalid, branch_rready;
  axil_resp_e                  branch_bresp, branch_rresp;

  logic [`AXIL_ADDR_WIDTH-1:0] trunk_awaddr, trunk_araddr;
  logic [`AXIL_DATA_WIDTH-1:0] trunk_wdata, trunk_rdata;
  logic [`AXIL_STRB_WIDTH-1:0] trunk_wstrb;
  logic                        trunk_awvalid, trunk_awready, trunk_wvalid, trunk_wready;
  logic                        trunk_bvalid, trunk_bready, trunk_arvalid, trunk_arready;
  logic                        trunk_rvalid, trunk_rready;
  axil_resp_e                  trunk_bresp, trunk_rresp;

  // All split ports share their names with the signals here
  axil_split axil_split_inst (.*);

  // Branch target with the control registers inside the window
  axil_reg_target branch_reg_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .awaddr  (branch_awaddr),
    .awvalid (branch_awvalid),
    .awready (branch_awready),
    .wdata   (branch_wdata),
    .wstrb   (branch_wstrb),
    .wvalid  (branch_wvalid),
    .wready  (branch_wready),
    .bresp   (branch_bresp),
    .bvalid  (branch_bvalid),
    .bready  (branch_bready),
    .araddr  (branch_araddr),
    .arvalid (branch_arvalid),
    .arready (branch_arready),
    .rdata   (branch_rdata),
    .rresp   (branch_rresp),
    .rvalid  (branch_rvalid),
    .rready  (branch_rready)
  );

  // Trunk target with the word memory for everything else
  axil_mem_target trunk_mem_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .awaddr  (trunk_awaddr),
    .awvalid (trunk_awvalid),
    .awready (trunk_awready),
    .wdata   (trunk_wdata),
    .wstrb   (trunk_wstrb),
    .wvalid  (trunk_wvalid),
    .wready  (trunk_wready),
    .bresp   (trunk_bresp),
    .bvalid  (trunk_bvalid),
    .bready  (trunk_bready),
    .araddr  (trunk_araddr),
    .arvalid (trunk_arvalid),
    .arready (trunk_arready),
    .rdata   (trunk_rdata),
    .rresp   (trunk_rresp),
    .rvalid  (trunk_rvalid),
    .rready  (trunk_rready)
  );

endmodule

// ==== testbench/tb_axil_split.sv ====
// Testbench for the AXI4-Lite split with register branch and memory trunk
`timescale 1ns/1ps
`include "axil_settings.svh"

module tb_axil_split;

  import axil_pkg::*;

  localparam int timeout_cycles = 200;
  localparam int rw_regs        = `AXIL_REG_COUNT - 2;
  localparam logic [`AXIL_ADDR_WIDTH-1:0] win_base = 16'h1000;

  logic                        clk;
  logic                        arst_n;
  logic [`AXIL_ADDR_WIDTH-1:0] branch_start_addr;
  logic [`AXIL_ADDR_WIDTH-1:0] branch_end_addr;
  logic [`AXIL_ADDR_WIDTH-1:0] root_awaddr;
  logic                        root_awvalid;
  logic                        root_awready;
  logic [`AXIL_DATA_WIDTH-1:0] root_wdata;
  logic [`AXIL_STRB_WIDTH-1:0] root_wstrb;
  logic                        root_wvalid;
  logic                        root_wready;
  axil_resp_e                  root_bresp;
  logic                        root_bvalid;
  logic                        root_bready;
  logic [`AXIL_ADDR_WIDTH-1:0] root_araddr;
  logic                        root_arvalid;
  logic                        root_arready;
  logic [`AXIL_DATA_WIDTH-1:0] root_rdata;
  axil_resp_e                  root_rresp;
  logic                        root_rvalid;
  logic                        root_rready;

  // Reference model state
  logic [`AXIL_DATA_WIDTH-1:0] model_mem [`AXIL_MEM_WORDS];
  logic [`AXIL_DATA_WIDTH-1:0] model_regs [rw_regs];
  logic [`AXIL_DATA_WIDTH-1:0] model_count;
  logic [`AXIL_DATA_WIDTH-1:0] rd_data_q [$];
  axil_resp_e                  rd_resp_q [$];
  axil_resp_e                  b_resp_q [$];

  // Held responses under back-pressure
  logic                        b_stalled  = 1'b0;
  logic                        r_stalled  = 1'b0;
  axil_resp_e                  held_bresp = OKAY;
  logic [`AXIL_DATA_WIDTH-1:0] held_rdata = '0;

  integer seed;
  int     err_count   = 0;
  int     pass_count  = 0;
  int     test_errors = 0;
  int     b_stall_cycles;
  logic   r_random;

  axil_split_top axil_split_top_inst (.*);

  always #10 clk = ~clk;

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic void expect_read(input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                                      output logic [`AXIL_DATA_WIDTH-1:0] data,
                                      output axil_resp_e resp);
    logic [2:0] idx;
    idx  = addr[4:2];
    resp = OKAY;
    if (addr >= branch_start_addr && addr <= branch_end_addr) begin
      if (idx < rw_regs) begin
        data = model_regs[idx];
      end else if (idx == rw_regs) begin
        data = `AXIL_REG_ID_VALUE;
      end else begin
        data = model_count;
      end
    end else begin
      data = model_mem[addr[9:2]];
    end
  endfunction

  // Applies an accepted write to the model and gives the expected bresp
  function automatic axil_resp_e apply_write(input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                                             input logic [`AXIL_DATA_WIDTH-1:0] data,
                                             input logic [`AXIL_STRB_WIDTH-1:0] strb);
    logic [2:0] idx;
    axil_resp_e resp;
    idx  = addr[4:2];
    resp = OKAY;
    if (addr >= branch_start_addr && addr <= branch_end_addr) begin
      if (idx < rw_regs) begin
        for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
          if (strb[b]) model_regs[idx][8*b +: 8] = data[8*b +: 8];
        end
        model_count = model_count + 1;
      end else begin
        resp = SLVERR;
      end
    end else begin
      for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
        if (strb[b]) model_mem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
    return resp;
  endfunction

  // Trunk address for a word, optionally in the upper alias range
  function automatic logic [`AXIL_ADDR_WIDTH-1:0] trunk_addr(input int word, input logic high);
    return {high, 5'b0, word[7:0], 2'b00};
  endfunction

  // ----------------------------------------------------------
  // Checking and reporting
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      err_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d errors", name, err_count - test_errors);
    test_errors = err_count;
  endtask

  task automatic give_up(input string what);
    $display("Timeout after %0d cycles, %s", timeout_cycles, what);
    $display("Simulation failed");
    $finish;
  endtask

  // Root handshakes are sampled at the rising edge
  always @(posedge clk) begin : response_monitor
    logic [`AXIL_DATA_WIDTH-1:0] exp_data;
    axil_resp_e                  exp_resp;
    if (arst_n) begin
      if (b_stalled) begin
        check_value("root_bvalid", 1, root_bvalid);
        check_value("root_bresp", held_bresp, root_bresp);
      end
      if (r_stalled) begin
        check_value("root_rvalid", 1, root_rvalid);
        check_value("root_rdata", held_rdata, root_rdata);
      end
      b_stalled  = root_bvalid && !root_bready;
      held_bresp = root_bresp;
      r_stalled  = root_rvalid && !root_rready;
      held_rdata = root_rdata;

      if (root_rvalid && root_rready) begin
        if (rd_data_q.size() == 0) begin
          $display("Read response at %0t with no read outstanding", $time);
          err_count++;
        end else begin
          check_value("root_rdata", rd_data_q.pop_front(), root_rdata);
          check_value("root_rresp", rd_resp_q.pop_front(), root_rresp);
        end
      end
      if (root_bvalid && root_bready) begin
        if (b_resp_q.size() == 0) begin
          $display("Write response at %0t with no write outstanding", $time);
          err_count++;
        end else begin
          check_value("root_bresp", b_resp_q.pop_front(), root_bresp);
        end
      end
      // A read in the same cycle as a write sees the old contents
      if (root_arvalid && root_arready) begin
        expect_read(root_araddr, exp_data, exp_resp);
        rd_data_q.push_back(exp_data);
        rd_resp_q.push_back(exp_resp);
      end
      // Write address and write data transfer in the same cycle
      if (root_awvalid && root_awready) begin
        check_value("root_wready", 1, root_wready);
        b_resp_q.push_back(apply_write(root_awaddr, root_wdata, root_wstrb));
      end
      if (root_wvalid && root_wready) begin
        check_value("root_awready", 1, root_awready);
      end
    end
  end

  // Response readys, decided at the edge and driven just after it
  always @(posedge clk) begin : ready_drive
    logic next_bready;
    logic next_rready;
    next_bready = (b_stall_cycles == 0);
    if (b_stall_cycles > 0) b_stall_cycles = b_stall_cycles - 1;
    next_rready = !r_random || (($random(seed) & 1) != 0);
    #2;
    root_bready = next_bready;
    root_rready = next_rready;
  end

  // ----------------------------------------------------------
  // Bus drivers
  // ----------------------------------------------------------
  task automatic write_req(input logic [`AXIL_ADDR_WIDTH-1:0] addr,
                           input logic [`AXIL_DATA_WIDTH-1:0] data,
                           input logic [`AXIL_STRB_WIDTH-1:0] strb);
    int cycles;
    cycles       = 0;
    root_awaddr  = addr;
    root_wdata   = data;
    root_wstrb   = strb;
    root_awvalid = 1'b1;
    root_wvalid  = 1'b1;
    @(posedge clk);
    while (!root_awready && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!root_awready) begin
      give_up($sformatf("write to %h never accepted", addr));
    end else begin
      #2;
      root_awvalid = 1'b0;
      root_wvalid  = 1'b0;
    end
  endtask

  task automatic read_req(input logic [`AXIL_ADDR_WIDTH-1:0] addr);
    int cycles;
    cycles       = 0;
    root_araddr  = addr;
    root_arvalid = 1'b1;
    @(posedge clk);
    while (!root_arready && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!root_arready) begin
      give_up($sformatf("read from %h never accepted", addr));
    end else begin
      #2;
      root_arvalid = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((rd_data_q.size() != 0 || b_resp_q.size() != 0) && cycles < timeout_cycles) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (rd_data_q.size() != 0 || b_resp_q.size() != 0) begin
      give_up("responses still outstanding");
    end
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    seed              = 47;
    clk               = 1'b0;
    arst_n            = 1'b0;
    branch_start_addr = win_base;
    branch_end_addr   = win_base + 31;
    root_awaddr       = '0;
    root_awvalid      = 1'b0;
    root_wdata        = '0;
    root_wstrb        = '0;
    root_wvalid       = 1'b0;
    root_bready       = 1'b1;
    root_araddr       = '0;
    root_arvalid      = 1'b0;
    root_rready       = 1'b1;
    b_stall_cycles    = 0;
    r_random          = 1'b0;
    model_count       = '0;
    for (int i = 0; i < rw_regs; i++) model_regs[i] = '0;

    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;
    check_value("root_bvalid", 0, root_bvalid);
    check_value("root_rvalid", 0, root_rvalid);
    @(posedge clk);
    #2;

    // Trunk words 0 to 15 get full writes first, then random strobed ones
    for (int i = 0; i < 16; i++) write_req(trunk_addr(i, 1'b0), $random(seed), 4'hF);
    for (int i = 0; i < 24; i++) begin
      write_req(trunk_addr($random(seed) & 15, $random(seed) & 1), $random(seed), $random(seed));
    end
    for (int i = 0; i < 16; i++) read_req(trunk_addr(i, $random(seed) & 1));
    wait_idle();
    report_test("trunk strobed writes and readback");

    for (int i = 0; i < rw_regs; i++) write_req(win_base + 4 * i, $random(seed), 4'hF);
    write_req(win_base + 4, 32'hA5A5_A5A5, 4'b0101);
    write_req(win_base + 8, 32'h1234_5678, 4'b1000);
    write_req(win_base + 20, $random(seed), 4'b0110);
    for (int i = 0; i < `AXIL_REG_COUNT; i++) read_req(win_base + 4 * i);
    wait_idle();
    report_test("branch registers, ID and write count");

    write_req(win_base + 24, 32'hDEAD_0006, 4'hF);
    write_req(win_base + 28, 32'hDEAD_0007, 4'hF);
    read_req(win_base + 24);
    read_req(win_base + 28);
    wait_idle();
    report_test("writes to read-only registers");

    // Four trunk reads in a row fill the read pipeline under back-pressure
    r_random = 1'b1;
    for (int i = 0; i < 4; i++) read_req(trunk_addr(i, 1'b0));
    for (int i = 0; i < 24; i++) begin
      if (i % 2 != 0) begin
        read_req(trunk_addr($random(seed) & 15, $random(seed) & 1));
      end else begin
        read_req(win_base + 4 * ($random(seed) & 7));
      end
    end
    wait_idle();
    r_random = 1'b0;
    report_test("interleaved reads in order");

    // Word 9 of the trunk now falls inside the window as register 1
    branch_start_addr = 16'h0020;
    branch_end_addr   = 16'h003F;
    @(posedge clk);
    #2;
    write_req(16'h0024, 32'hC0DE_0024, 4'hF);
    read_req(16'h0024);
    read_req(16'h8024);
    read_req(16'h0038);
    wait_idle();
    branch_start_addr = win_base;
    branch_end_addr   = win_base + 31;
    @(posedge clk);
    #2;
    report_test("moved window");

    b_stall_cycles = 12;
    @(posedge clk);
    #2;
    write_req(trunk_addr(20, 1'b0), 32'h600D_0001, 4'hF);
    write_req(trunk_addr(21, 1'b0), 32'h600D_0002, 4'hF);
    write_req(win_base + 8, 32'h600D_0003, 4'hF);
    wait_idle();
    read_req(trunk_addr(20, 1'b0));
    read_req(trunk_addr(21, 1'b0));
    read_req(win_base + 8);
    wait_idle();
    report_test("write responses under back-pressure");

    $display("Checks passed: %0d, errors: %0d", pass_count, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
